// ==== include/qdr_replay_defines.svh ====
/*
 * Widths and depths shared by the packet capture and replay engine
 */

`ifndef QDR_REPLAY_DEFINES_SVH
`define QDR_REPLAY_DEFINES_SVH

// Stream widths
`define AXIS_DATA_W     256
`define HALF_DATA_W     128

// Replay memory holds 2**MEM_ADDR_W half beats
`define MEM_ADDR_W      10
`define REPLAY_CNT_W    16

// Read-side buffer
`define FIFO_DEPTH_BITS 3
`define FIFO_SLACK      2

`endif

// ==== logic/axis_pkg.sv ====
/*
 * Stream beat types: 256-bit full beats on the external ports and
 * 128-bit half beats between stages and in the replay memory
 */

`include "qdr_replay_defines.svh"

package axis_pkg;

   typedef logic [`AXIS_DATA_W-1:0]   axis_data_t;
   typedef logic [`AXIS_DATA_W/8-1:0] axis_keep_t;
   typedef logic [`HALF_DATA_W-1:0]   half_data_t;
   typedef logic [`HALF_DATA_W/8-1:0] half_keep_t;

   typedef struct packed {
      axis_data_t data;
      axis_keep_t keep;
      logic       last;
   } axis_beat_t;

   typedef struct packed {
      half_data_t data;
      half_keep_t keep;
      logic       last;
   } half_beat_t;

endpackage

// ==== logic/replay_pkg.sv ====
/*
 * Replay memory address, pass count and controller mode types
 */

`include "qdr_replay_defines.svh"

package replay_pkg;

   typedef logic [`MEM_ADDR_W-1:0]   mem_addr_t;
   typedef logic [`REPLAY_CNT_W-1:0] replay_cnt_t;

   typedef enum logic [1:0] {
      ST_CAPTURE,
      ST_HOLD,
      ST_REPLAY
   } replay_state_e;

endpackage

// ==== logic/pkt_narrow.sv ====
/*
 * Full beat to half beat converter
 * Low half goes first, an empty upper half of a last beat is dropped
 */

`timescale 1ns/10ps
`include "qdr_replay_defines.svh"

module pkt_narrow (
   input  logic                 clk,
   input  logic                 reset_i,
   input  axis_pkg::axis_beat_t beat_i,
   input  logic                 valid_i,
   output logic                 ready_o,
   output axis_pkg::half_beat_t half_o,
   output logic                 half_valid_o,
   input  logic                 half_ready_i
);
   import axis_pkg::*;

   axis_beat_t beat_q;
   logic       full_q;
   logic       hi_q;
   logic       skip_hi;
   half_beat_t lo_half;
   half_beat_t hi_half;

   assign skip_hi = beat_q.last && (beat_q.keep[`AXIS_DATA_W/8-1:`HALF_DATA_W/8] == '0);

   assign lo_half.data = beat_q.data[`HALF_DATA_W-1:0];
   assign lo_half.keep = beat_q.keep[`HALF_DATA_W/8-1:0];
   assign lo_half.last = skip_hi;
   assign hi_half.data = beat_q.data[`AXIS_DATA_W-1:`HALF_DATA_W];
   assign hi_half.keep = beat_q.keep[`AXIS_DATA_W/8-1:`HALF_DATA_W/8];
   assign hi_half.last = beat_q.last;

   assign half_o       = hi_q ? hi_half : lo_half;
   assign half_valid_o = full_q;
   assign ready_o      = !full_q;

   always_ff @(posedge clk) begin
      if (valid_i && ready_o)
         beat_q <= beat_i;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         full_q <= 1'b0;
         hi_q   <= 1'b0;
      end else if (valid_i && ready_o) begin
         full_q <= 1'b1;
         hi_q   <= 1'b0;
      end else if (full_q && half_ready_i) begin
         // Second half pending unless this was the only one
         if (hi_q || skip_hi) begin
            full_q <= 1'b0;
            hi_q   <= 1'b0;
         end else begin
            hi_q <= 1'b1;
         end
      end
   end

endmodule

// ==== logic/replay_ctrl.sv ====
/*
 * Capture write addressing and replay read sequencer
 * Modes are capture, hold and replay
 */

`timescale 1ns/10ps

module replay_ctrl (
   input  logic                    clk,
   input  logic                    reset_i,
   input  axis_pkg::half_beat_t    half_i,
   input  logic                    half_valid_i,
   output logic                    half_ready_o,
   input  logic                    sw_rst_i,
   input  logic                    wr_done_i,
   input  logic                    start_replay_i,
   input  replay_pkg::replay_cnt_t replay_count_i,
   output logic                    replay_busy_o,
   input  logic                    fifo_nearly_full_i,
   output logic                    mem_wr_en_o,
   output replay_pkg::mem_addr_t   mem_wr_addr_o,
   output axis_pkg::half_beat_t    mem_wr_data_o,
   output logic                    mem_rd_en_o,
   output replay_pkg::mem_addr_t   mem_rd_addr_o
);
   import replay_pkg::*;

   replay_state_e state_q;
   mem_addr_t     wr_ptr_q;
   mem_addr_t     wr_ptr_next;
   mem_addr_t     end_addr_q;
   mem_addr_t     last_rd_addr;
   mem_addr_t     rd_ptr_q;
   replay_cnt_t   pass_cnt_q;
   logic          mem_full_q;
   logic          wr_fire;
   logic          have_data;

   assign half_ready_o  = (state_q == ST_CAPTURE) && !mem_full_q;
   assign wr_fire       = half_valid_i && half_ready_o;
   assign wr_ptr_next   = wr_fire ? wr_ptr_q + mem_addr_t'(1) : wr_ptr_q;
   assign mem_wr_en_o   = wr_fire;
   assign mem_wr_addr_o = wr_ptr_q;
   assign mem_wr_data_o = half_i;

   assign mem_rd_en_o   = (state_q == ST_REPLAY) && !fifo_nearly_full_i;
   assign mem_rd_addr_o = rd_ptr_q;
   assign replay_busy_o = (state_q == ST_REPLAY);

   // A completely filled memory leaves the end address wrapped to zero
   assign have_data    = (end_addr_q != '0) || mem_full_q;
   assign last_rd_addr = end_addr_q - mem_addr_t'(1);

   always_ff @(posedge clk) begin
      if (reset_i || sw_rst_i) begin
         state_q    <= ST_CAPTURE;
         wr_ptr_q   <= '0;
         end_addr_q <= '0;
         rd_ptr_q   <= '0;
         pass_cnt_q <= '0;
         mem_full_q <= 1'b0;
      end else begin
         wr_ptr_q <= wr_ptr_next;
         if (wr_fire && (wr_ptr_q == '1))
            mem_full_q <= 1'b1;

         case (state_q)
            ST_CAPTURE: begin
               if (wr_done_i) begin
                  state_q    <= ST_HOLD;
                  end_addr_q <= wr_ptr_next;
               end
            end
            ST_HOLD: begin
               if (start_replay_i && (replay_count_i != '0) && have_data) begin
                  state_q    <= ST_REPLAY;
                  rd_ptr_q   <= '0;
                  pass_cnt_q <= replay_count_i;
               end
            end
            ST_REPLAY: begin
               if (mem_rd_en_o) begin
                  if (rd_ptr_q == last_rd_addr) begin
                     rd_ptr_q   <= '0;
                     pass_cnt_q <= pass_cnt_q - replay_cnt_t'(1);
                     if (pass_cnt_q == replay_cnt_t'(1))
                        state_q <= ST_HOLD;
                  end else begin
                     rd_ptr_q <= rd_ptr_q + mem_addr_t'(1);
                  end
               end
            end
            default: state_q <= ST_CAPTURE;
         endcase
      end
   end

endmodule

// ==== logic/replay_mem.sv ====
/*
 * On-chip replay memory of half beats
 * One write port, one registered read port with a valid pulse
 */

`timescale 1ns/10ps
`include "qdr_replay_defines.svh"

module replay_mem (
   input  logic                  clk,
   input  logic                  reset_i,
   input  logic                  wr_en_i,
   input  replay_pkg::mem_addr_t wr_addr_i,
   input  axis_pkg::half_beat_t  wr_data_i,
   input  logic                  rd_en_i,
   input  replay_pkg::mem_addr_t rd_addr_i,
   output logic                  rd_valid_o,
   output axis_pkg::half_beat_t  rd_data_o
);
   import axis_pkg::*;

   half_beat_t mem [2**`MEM_ADDR_W];

   always_ff @(posedge clk) begin
      if (wr_en_i)
         mem[wr_addr_i] <= wr_data_i;
      if (rd_en_i)
         rd_data_o <= mem[rd_addr_i];
   end

   // Word is valid one cycle after the read request
   always_ff @(posedge clk) begin
      if (reset_i)
         rd_valid_o <= 1'b0;
      else
         rd_valid_o <= rd_en_i;
   end

endmodule

// ==== logic/replay_fifo.sv ====
/*
 * Fall-through FIFO behind the replay memory
 * nearly_full_o leaves room for the reads still in flight
 */

`timescale 1ns/10ps
`include "qdr_replay_defines.svh"

module replay_fifo #(
   parameter int DEPTH_BITS = `FIFO_DEPTH_BITS
) (
   input  logic                 clk,
   input  logic                 reset_i,
   input  logic                 wr_en_i,
   input  axis_pkg::half_beat_t wr_data_i,
   output axis_pkg::half_beat_t rd_data_o,
   output logic                 valid_o,
   input  logic                 ready_i,
   output logic                 nearly_full_o
);
   import axis_pkg::*;

   localparam int DEPTH = 2**DEPTH_BITS;

   half_beat_t            mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr_q;
   logic [DEPTH_BITS-1:0] rd_ptr_q;
   logic [DEPTH_BITS:0]   count_q;
   logic                  pop;

   assign valid_o       = (count_q != '0);
   assign rd_data_o     = mem[rd_ptr_q];
   assign pop           = valid_o && ready_i;
   assign nearly_full_o = (count_q > (DEPTH_BITS+1)'(DEPTH - `FIFO_SLACK));

   always_ff @(posedge clk) begin
      if (wr_en_i)
         mem[wr_ptr_q] <= wr_data_i;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_en_i)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (wr_en_i && !pop)
            count_q <= count_q + 1'b1;
         else if (pop && !wr_en_i)
            count_q <= count_q - 1'b1;
      end
   end

endmodule

// ==== logic/pkt_widen.sv ====
/*
 * Half beat to full beat converter
 * Pairs low and high halves, a last low half closes a beat on its own
 */

`timescale 1ns/10ps

module pkt_widen (
   input  logic                 clk,
   input  logic                 reset_i,
   input  axis_pkg::half_beat_t half_i,
   input  logic                 half_valid_i,
   output logic                 half_ready_o,
   output axis_pkg::axis_beat_t beat_o,
   output logic                 valid_o,
   input  logic                 ready_i
);
   import axis_pkg::*;

   half_beat_t lo_q;
   logic       have_lo_q;
   logic       form_beat;
   logic       slot_free;
   logic       half_fire;
   axis_beat_t beat_d;

   // Only a completing half needs the output register
   assign form_beat    = have_lo_q || half_i.last;
   assign slot_free    = !valid_o || ready_i;
   assign half_ready_o = !form_beat || slot_free;
   assign half_fire    = half_valid_i && half_ready_o;

   always_comb begin
      if (have_lo_q) begin
         beat_d.data = {half_i.data, lo_q.data};
         beat_d.keep = {half_i.keep, lo_q.keep};
      end else begin
         beat_d.data = {half_data_t'(0), half_i.data};
         beat_d.keep = {half_keep_t'(0), half_i.keep};
      end
      beat_d.last = half_i.last;
   end

   always_ff @(posedge clk) begin
      if (half_fire && !form_beat)
         lo_q <= half_i;
      if (half_fire && form_beat)
         beat_o <= beat_d;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         have_lo_q <= 1'b0;
         valid_o   <= 1'b0;
      end else begin
         if (half_fire)
            have_lo_q <= !form_beat;
         if (half_fire && form_beat)
            valid_o <= 1'b1;
         else if (ready_i)
            valid_o <= 1'b0;
      end
   end

endmodule

// ==== logic/qdr_replay_top.sv ====
/*
 * Packet capture and replay engine
 * Narrowing, capture and replay control with memory, buffering, widening
 */

`timescale 1ns/10ps

module qdr_replay_top (
   input  logic                    clk,
   input  logic                    reset_i,
   input  axis_pkg::axis_beat_t    s_axis_beat_i,
   input  logic                    s_axis_valid_i,
   output logic                    s_axis_ready_o,
   output axis_pkg::axis_beat_t    m_axis_beat_o,
   output logic                    m_axis_valid_o,
   input  logic                    m_axis_ready_i,
   input  logic                    sw_rst_i,
   input  logic                    wr_done_i,
   input  logic                    start_replay_i,
   input  replay_pkg::replay_cnt_t replay_count_i,
   output logic                    replay_busy_o
);
   import axis_pkg::*;
   import replay_pkg::*;

   half_beat_t nar_half, mem_wr_data, mem_rd_data, fifo_half;
   logic       nar_valid, nar_ready;
   logic       mem_wr_en, mem_rd_en, mem_rd_valid;
   mem_addr_t  mem_wr_addr, mem_rd_addr;
   logic       fifo_valid, fifo_ready, fifo_nearly_full;

   pkt_narrow u_pkt_narrow (
      .clk(clk), .reset_i(reset_i),
      .beat_i(s_axis_beat_i), .valid_i(s_axis_valid_i), .ready_o(s_axis_ready_o),
      .half_o(nar_half), .half_valid_o(nar_valid), .half_ready_i(nar_ready)
   );

   replay_ctrl u_replay_ctrl (
      .clk(clk), .reset_i(reset_i),
      .half_i(nar_half), .half_valid_i(nar_valid), .half_ready_o(nar_ready),
      .sw_rst_i(sw_rst_i), .wr_done_i(wr_done_i), .start_replay_i(start_replay_i),
      .replay_count_i(replay_count_i), .replay_busy_o(replay_busy_o),
      .fifo_nearly_full_i(fifo_nearly_full),
      .mem_wr_en_o(mem_wr_en), .mem_wr_addr_o(mem_wr_addr), .mem_wr_data_o(mem_wr_data),
      .mem_rd_en_o(mem_rd_en), .mem_rd_addr_o(mem_rd_addr)
   );

   replay_mem u_replay_mem (
      .clk(clk), .reset_i(reset_i),
      .wr_en_i(mem_wr_en), .wr_addr_i(mem_wr_addr), .wr_data_i(mem_wr_data),
      .rd_en_i(mem_rd_en), .rd_addr_i(mem_rd_addr),
      .rd_valid_o(mem_rd_valid), .rd_data_o(mem_rd_data)
   );

   // Read data lands straight in the buffer, the controller throttles on nearly full
   replay_fifo u_replay_fifo (
      .clk(clk), .reset_i(reset_i),
      .wr_en_i(mem_rd_valid), .wr_data_i(mem_rd_data),
      .rd_data_o(fifo_half), .valid_o(fifo_valid), .ready_i(fifo_ready),
      .nearly_full_o(fifo_nearly_full)
   );

   pkt_widen u_pkt_widen (
      .clk(clk), .reset_i(reset_i),
      .half_i(fifo_half), .half_valid_i(fifo_valid), .half_ready_o(fifo_ready),
      .beat_o(m_axis_beat_o), .valid_o(m_axis_valid_o), .ready_i(m_axis_ready_i)
   );

endmodule

// ==== sim/tb_qdr_replay.sv ====
/*
 * Testbench for the packet capture and replay engine
 * Clock, reset, random packet stimulus, expected beat queue and assertions
 */

`timescale 1ns/10ps

module tb_qdr_replay;
   import axis_pkg::*;
   import replay_pkg::*;

   localparam int WAIT_LIMIT  = 200;
   localparam int DRAIN_LIMIT = 5000;

   logic        clk;
   logic        reset_i;
   axis_beat_t  s_axis_beat_i;
   logic        s_axis_valid_i;
   logic        s_axis_ready_o;
   axis_beat_t  m_axis_beat_o;
   logic        m_axis_valid_o;
   logic        m_axis_ready_i = 1'b1;
   logic        sw_rst_i;
   logic        wr_done_i;
   logic        start_replay_i;
   replay_cnt_t replay_count_i;
   logic        replay_busy_o;

   string       test_name = "reset";
   logic        bp_on = 1'b0;
   axis_beat_t  cap_q [$];
   axis_beat_t  exp_q [$];

   qdr_replay_top u_qdr_replay_top (
      .clk(clk), .reset_i(reset_i),
      .s_axis_beat_i(s_axis_beat_i), .s_axis_valid_i(s_axis_valid_i),
      .s_axis_ready_o(s_axis_ready_o),
      .m_axis_beat_o(m_axis_beat_o), .m_axis_valid_o(m_axis_valid_o),
      .m_axis_ready_i(m_axis_ready_i),
      .sw_rst_i(sw_rst_i), .wr_done_i(wr_done_i), .start_replay_i(start_replay_i),
      .replay_count_i(replay_count_i), .replay_busy_o(replay_busy_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic value_error(input string what, input logic [288:0] exp_v,
                              input logic [288:0] act_v);
      $display("Error: %s %s expected %h actual %h", test_name, what, exp_v, act_v);
      $display("Regression failed");
      $fatal(1, "Wrong value seen");
   endtask

   task automatic plain_error(input string why);
      $display("%s during %s", why, test_name);
      $display("Regression failed");
      $fatal(1, "Run stopped");
   endtask

   // Output beat that a captured input beat turns into
   function automatic axis_beat_t expected_beat(input axis_beat_t b);
      axis_beat_t e;
      e = b;
      for (int i = 0; i < 32; i++)
         if (!b.keep[i])
            e.data[i*8 +: 8] = 8'h00;
      if (b.last && (b.keep[31:16] == '0)) begin
         e.data[255:128] = '0;
         e.keep[31:16]   = '0;
      end
      return e;
   endfunction

   // Lanes without keep are zero except in an upper half that is never sent
   function automatic axis_beat_t random_beat(input logic last, input int nbytes);
      axis_beat_t b;
      logic       hi_empty;
      for (int w = 0; w < 8; w++)
         b.data[w*32 +: 32] = $urandom();
      b.keep = last ? axis_keep_t'((33'd1 << nbytes) - 33'd1) : '1;
      b.last = last;
      hi_empty = last && (b.keep[31:16] == '0);
      for (int i = 0; i < 32; i++)
         if (!b.keep[i] && !(hi_empty && i >= 16))
            b.data[i*8 +: 8] = 8'h00;
      return b;
   endfunction

   task automatic send_beat(input axis_beat_t b);
      int waited;
      waited = 0;
      @(posedge clk);
      s_axis_beat_i  <= b;
      s_axis_valid_i <= 1'b1;
      @(negedge clk);
      while (!s_axis_ready_o) begin
         waited++;
         if (waited > WAIT_LIMIT)
            plain_error("Input stream never accepted a beat");
         @(negedge clk);
      end
      @(posedge clk);
      s_axis_valid_i <= 1'b0;
   endtask

   task automatic send_packet(input int nbeats, input int tail_bytes);
      axis_beat_t b;
      for (int i = 0; i < nbeats; i++) begin
         b = random_beat(i == nbeats - 1, tail_bytes);
         cap_q.push_back(expected_beat(b));
         send_beat(b);
      end
   endtask

   task automatic capture_packets(input int npkts);
      for (int p = 0; p < npkts; p++)
         send_packet($urandom_range(1, 4), $urandom_range(1, 32));
   endtask

   task automatic wait_input_idle();
      int waited;
      waited = 0;
      @(negedge clk);
      while (!s_axis_ready_o) begin
         waited++;
         if (waited > WAIT_LIMIT)
            plain_error("Input stream did not become ready");
         @(negedge clk);
      end
   endtask

   task automatic end_capture();
      wait_input_idle();
      @(posedge clk);
      wr_done_i <= 1'b1;
      @(posedge clk);
      wr_done_i <= 1'b0;
   endtask

   task automatic pulse_start(input replay_cnt_t count);
      @(posedge clk);
      start_replay_i <= 1'b1;
      replay_count_i <= count;
      @(posedge clk);
      start_replay_i <= 1'b0;
   endtask

   task automatic wait_busy(input logic level);
      int waited;
      waited = 0;
      @(negedge clk);
      while (replay_busy_o != level) begin
         waited++;
         if (waited > DRAIN_LIMIT)
            plain_error("Replay busy flag never reached the awaited level");
         @(negedge clk);
      end
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      @(negedge clk);
      while (exp_q.size() != 0) begin
         waited++;
         if (waited > DRAIN_LIMIT)
            plain_error("Output stream stopped before all expected beats arrived");
         @(negedge clk);
      end
   endtask

   task automatic replay(input int count);
      for (int p = 0; p < count; p++)
         foreach (cap_q[i])
            exp_q.push_back(cap_q[i]);
      pulse_start(replay_cnt_t'(count));
      wait_busy(1'b1);
      wait_busy(1'b0);
      // Last read is still in flight when the controller leaves replay
      assert (exp_q.size() != 0)
         else plain_error("Busy stayed high until the output stream had drained");
      wait_drained();
      // Window for stray beats beyond the expected ones
      repeat (10) @(negedge clk);
   endtask

   // Random sink stalls
   always @(posedge clk)
      m_axis_ready_i <= bp_on ? ($urandom_range(0, 2) != 0) : 1'b1;

   always @(negedge clk) begin : out_monitor
      axis_beat_t exp_b;
      if (!reset_i) begin
         assert (!m_axis_valid_o || exp_q.size() != 0)
            else plain_error("Output beat appeared with none expected");
         if (m_axis_valid_o && m_axis_ready_i) begin
            exp_b = exp_q.pop_front();
            assert (m_axis_beat_o == exp_b)
               else value_error("output beat", exp_b, m_axis_beat_o);
         end
      end
   end

   stall_hold: assert property (@(posedge clk) disable iff (reset_i)
      (m_axis_valid_o && !m_axis_ready_i) |=> (m_axis_valid_o && $stable(m_axis_beat_o)))
      else plain_error("Stalled output beat changed before it was accepted");

   initial begin
      void'($urandom(32'he09c_b891));
      reset_i        = 1'b1;
      s_axis_beat_i  = '0;
      s_axis_valid_i = 1'b0;
      sw_rst_i       = 1'b0;
      wr_done_i      = 1'b0;
      start_replay_i = 1'b0;
      replay_count_i = '0;
      repeat (2) @(posedge clk);
      reset_i <= 1'b0;

      test_name = "after reset";
      @(negedge clk);
      assert (!replay_busy_o) else value_error("replay_busy_o", 0, replay_busy_o);
      assert (!m_axis_valid_o) else value_error("m_axis_valid_o", 0, m_axis_valid_o);
      wait_input_idle();

      // Short tails exercise the dropped upper half
      test_name = "single replay";
      send_packet(1, 8);
      send_packet(3, 16);
      send_packet(2, 20);
      capture_packets(4);
      end_capture();
      replay(1);

      test_name = "multiple passes";
      replay(3);

      test_name = "back-pressure";
      bp_on <= 1'b1;
      replay(2);
      bp_on <= 1'b0;

      test_name = "software reset";
      pulse_start(0);
      repeat (20) begin
         @(negedge clk);
         assert (!replay_busy_o) else value_error("replay_busy_o", 0, replay_busy_o);
      end
      @(posedge clk);
      sw_rst_i <= 1'b1;
      @(posedge clk);
      sw_rst_i <= 1'b0;
      cap_q.delete();
      capture_packets(3);
      send_packet(1, 4);
      end_capture();
      replay(1);

      $display("Regression passed");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+include
logic/axis_pkg.sv
logic/replay_pkg.sv
logic/pkt_narrow.sv
logic/replay_ctrl.sv
logic/replay_mem.sv
logic/replay_fifo.sv
logic/pkt_widen.sv
logic/qdr_replay_top.sv
sim/tb_qdr_replay.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
   -f verilog.f --top-module tb_qdr_replay -o tb_qdr_replay
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/tb_qdr_replay
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
fi
exit $status
